//--- source/portalPkg.sv
`default_nettype none

package portalPkg;

  // Bus and message widths
  localparam int DataWidth  = 32;
  localparam int AddrWidth  = 13;
  localparam int MsgWords   = 4;
  localparam int MsgWidth   = MsgWords * DataWidth;
  localparam int CountWidth = 16;

  // Control page offsets
  localparam logic [4:0] OffIntStatus   = 5'h00;
  localparam logic [4:0] OffIntEnable   = 5'h04;
  localparam logic [4:0] OffNumTiles    = 5'h08;
  localparam logic [4:0] OffQueueStatus = 5'h0C;
  localparam logic [4:0] OffPortalId    = 5'h10;
  localparam logic [4:0] OffNumPortals  = 5'h14;

  // Data page offsets
  localparam logic [4:0] OffData    = 5'h00;
  localparam logic [4:0] OffNotFull = 5'h04;

  localparam logic [DataWidth-1:0] IndPortalId   = 32'd5;
  localparam logic [DataWidth-1:0] ReqPortalId   = 32'd6;
  localparam logic [DataWidth-1:0] NumTiles      = 32'd1;
  localparam logic [DataWidth-1:0] NumPortals    = 32'd2;
  localparam logic [DataWidth-1:0] UnusedPattern = 32'h005A05A0;

  localparam logic [1:0] RespOkay = 2'b00;

  // Field order follows address bits 12, 11:5, 4:0
  typedef struct packed {
    logic       reqPortal;
    logic [6:0] page;      // Zero is the control page
    logic [4:0] offset;
  } portalAddrT;

  typedef struct packed {
    logic                 valid;
    portalAddrT           addr;
    logic [DataWidth-1:0] data;
  } regWriteT;

  typedef struct packed {
    logic       valid;
    portalAddrT addr;
  } regReadT;

endpackage

`default_nettype wire

//--- source/axiLiteSlave.sv
`default_nettype none

module axiLiteSlave import portalPkg::*; (
  input  wire                  CLK,
  input  wire                  RST_N,

  // Write address and data
  input  wire [AddrWidth-1:0]  awAddr,
  input  wire                  awValid,
  output logic                 awReady,
  input  wire [DataWidth-1:0]  wData,
  input  wire                  wValid,
  output logic                 wReady,

  // Write response
  output logic                 bValid,
  input  wire                  bReady,
  output logic [1:0]           bResp,

  // Read address and data
  input  wire [AddrWidth-1:0]  arAddr,
  input  wire                  arValid,
  output logic                 arReady,
  output logic                 rValid,
  input  wire                  rReady,
  output logic [DataWidth-1:0] rData,
  output logic [1:0]           rResp,

  // Register side
  input  wire                  writeAccept,
  input  wire [DataWidth-1:0]  rdData,
  output regWriteT             regWr,
  output regReadT              regRd
);

  logic writeFire;
  logic readFire;

  // AW and W taken together, one write outstanding
  assign writeFire = awValid && wValid && !bValid && writeAccept;
  assign awReady   = writeFire;
  assign wReady    = writeFire;

  assign arReady  = !rValid;
  assign readFire = arValid && arReady;

  assign bResp = RespOkay;
  assign rResp = RespOkay;

  // Address is always presented, valid only on the accepting cycle
  always_comb begin
    regWr.valid = writeFire;
    regWr.addr  = portalAddrT'(awAddr);
    regWr.data  = wData;
    regRd.valid = readFire;
    regRd.addr  = portalAddrT'(arAddr);
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      bValid <= 1'b0;
    end else if (writeFire) begin
      bValid <= 1'b1;
    end else if (bReady) begin
      bValid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      rValid <= 1'b0;
    end else if (readFire) begin
      rValid <= 1'b1;
    end else if (rReady) begin
      rValid <= 1'b0;
    end
  end

  // Read word sampled on AR acceptance, held until taken
  always_ff @(posedge CLK) begin
    if (readFire) begin
      rData <= rdData;
    end
  end

endmodule

`default_nettype wire

//--- source/portalRegs.sv
`default_nettype none

module portalRegs import portalPkg::*; (
  input  wire                   CLK,
  input  wire                   RST_N,
  input  regWriteT              regWr,
  input  regReadT               regRd,
  input  wire [DataWidth-1:0]   indWord,
  input  wire [CountWidth-1:0]  remain,
  input  wire                   reqFull,
  output logic [DataWidth-1:0]  rdData,
  output logic                  reqWordWr,
  output logic                  msgDone,
  output logic [DataWidth-1:0]  wrData,
  output logic                  indPop,
  output logic                  interrupt
);

  portalAddrT wrAddr;
  portalAddrT rdAddr;
  logic       wrIsData;
  logic       rdIsData;
  logic       remainNz;
  logic       intEnable;

  assign wrAddr   = regWr.addr;
  assign rdAddr   = regRd.addr;
  assign wrIsData = (wrAddr.page != 7'd0);
  assign rdIsData = (rdAddr.page != 7'd0);
  assign remainNz = (remain != '0);

  // Request data page, any nonzero offset ends the message
  assign reqWordWr = regWr.valid && wrAddr.reqPortal && wrIsData;
  assign msgDone   = wrAddr.reqPortal && wrIsData && (wrAddr.offset != OffData);
  assign wrData    = regWr.data;

  assign indPop = regRd.valid && !rdAddr.reqPortal && rdIsData && (rdAddr.offset == OffData);

  assign interrupt = remainNz && intEnable;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      intEnable <= 1'b0;
    end else if (regWr.valid && !wrIsData && (wrAddr.offset == OffIntEnable)) begin
      intEnable <= regWr.data[0];  // Shared by both portals
    end
  end

  always_comb begin
    rdData = '0;
    if (!rdIsData) begin
      case (rdAddr.offset)
        OffIntStatus:   rdData = {31'd0, remainNz && !rdAddr.reqPortal};
        OffNumTiles:    rdData = NumTiles;
        OffQueueStatus: rdData = {31'd0, remainNz && !rdAddr.reqPortal};
        OffPortalId:    rdData = rdAddr.reqPortal ? ReqPortalId : IndPortalId;
        OffNumPortals:  rdData = NumPortals;
        default:        rdData = UnusedPattern;
      endcase
    end else if (rdAddr.offset == OffData && !rdAddr.reqPortal) begin
      rdData = indWord;
    end else if (rdAddr.offset == OffNotFull) begin
      rdData = {31'd0, !reqFull};  // Space for another message
    end
  end

endmodule

`default_nettype wire

//--- source/requestAssembler.sv
`default_nettype none

module requestAssembler import portalPkg::*; (
  input  wire                  CLK,
  input  wire                  RST_N,
  input  wire                  reqWordWr,
  input  wire                  msgDone,
  input  wire [DataWidth-1:0]  wrData,
  input  wire                  reqMsgReady,
  output logic                 writeAccept,
  output logic                 reqFull,
  output logic [MsgWidth-1:0]  reqMsg,
  output logic                 reqMsgValid
);

  logic [MsgWidth-1:0] msgBuf;
  logic [MsgWidth-1:0] shifted;

  // Oldest word ends up in the top slot
  assign shifted = {msgBuf[(MsgWords-1)*DataWidth-1:0], wrData};

  // Only a completing write waits for the previous message
  assign writeAccept = !(msgDone && reqMsgValid);
  assign reqFull     = reqMsgValid;

  always_ff @(posedge CLK) begin
    if (reqWordWr) begin
      msgBuf <= shifted;
    end
  end

  always_ff @(posedge CLK) begin
    if (reqWordWr && msgDone) begin
      reqMsg <= shifted;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      reqMsgValid <= 1'b0;
    end else begin
      if (reqMsgValid && reqMsgReady) begin
        reqMsgValid <= 1'b0;
      end
      if (reqWordWr && msgDone) begin
        reqMsgValid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/indicationReader.sv
`default_nettype none

module indicationReader import portalPkg::*; (
  input  wire                   CLK,
  input  wire                   RST_N,
  input  wire [MsgWidth-1:0]    indMsg,
  input  wire                   indMsgValid,
  input  wire                   indPop,
  output logic                  indMsgReady,
  output logic [DataWidth-1:0]  indWord,
  output logic [CountWidth-1:0] remain
);

  logic [MsgWidth-1:0] msgBuf;
  logic                load;
  logic                pop;

  // New message only once the previous one is drained
  assign indMsgReady = (remain == '0);
  assign load        = indMsgValid && indMsgReady;
  assign pop         = indPop && (remain != '0);

  assign indWord = msgBuf[DataWidth-1:0];

  always_ff @(posedge CLK) begin
    if (load) begin
      msgBuf <= indMsg;
    end else if (pop) begin
      msgBuf <= msgBuf >> DataWidth;
    end
  end

  // Word count comes from the header word itself
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      remain <= '0;
    end else if (load) begin
      remain <= indMsg[CountWidth-1:0];
    end else if (pop) begin
      remain <= remain - CountWidth'(1);
    end
  end

endmodule

`default_nettype wire

//--- source/portalTop.sv
`default_nettype none

module portalTop import portalPkg::*; (
  input  wire                  CLK,
  input  wire                  RST_N,

  // AXI4-Lite slave
  input  wire [AddrWidth-1:0]  awAddr,
  input  wire                  awValid,
  output logic                 awReady,
  input  wire [DataWidth-1:0]  wData,
  input  wire                  wValid,
  output logic                 wReady,
  output logic                 bValid,
  input  wire                  bReady,
  output logic [1:0]           bResp,
  input  wire [AddrWidth-1:0]  arAddr,
  input  wire                  arValid,
  output logic                 arReady,
  output logic                 rValid,
  input  wire                  rReady,
  output logic [DataWidth-1:0] rData,
  output logic [1:0]           rResp,

  // User core channels
  output logic [MsgWidth-1:0]  reqMsg,
  output logic                 reqMsgValid,
  input  wire                  reqMsgReady,
  input  wire [MsgWidth-1:0]   indMsg,
  input  wire                  indMsgValid,
  output logic                 indMsgReady,

  output logic                 interrupt
);

  regWriteT              regWr;
  regReadT               regRd;
  logic [DataWidth-1:0]  rdData;
  logic                  writeAccept;
  logic                  reqWordWr;
  logic                  msgDone;
  logic [DataWidth-1:0]  wrData;
  logic                  reqFull;
  logic                  indPop;
  logic [DataWidth-1:0]  indWord;
  logic [CountWidth-1:0] remain;

  axiLiteSlave axiLiteSlave_inst (
    .CLK(CLK), .RST_N(RST_N),
    .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wValid(wValid), .wReady(wReady),
    .bValid(bValid), .bReady(bReady), .bResp(bResp),
    .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp),
    .writeAccept(writeAccept), .rdData(rdData),
    .regWr(regWr), .regRd(regRd)
  );

  portalRegs portalRegs_inst (
    .CLK(CLK), .RST_N(RST_N),
    .regWr(regWr), .regRd(regRd),
    .indWord(indWord), .remain(remain), .reqFull(reqFull),
    .rdData(rdData), .reqWordWr(reqWordWr), .msgDone(msgDone),
    .wrData(wrData), .indPop(indPop), .interrupt(interrupt)
  );

  requestAssembler requestAssembler_inst (
    .CLK(CLK), .RST_N(RST_N),
    .reqWordWr(reqWordWr), .msgDone(msgDone), .wrData(wrData),
    .reqMsgReady(reqMsgReady), .writeAccept(writeAccept), .reqFull(reqFull),
    .reqMsg(reqMsg), .reqMsgValid(reqMsgValid)
  );

  indicationReader indicationReader_inst (
    .CLK(CLK), .RST_N(RST_N),
    .indMsg(indMsg), .indMsgValid(indMsgValid), .indPop(indPop),
    .indMsgReady(indMsgReady), .indWord(indWord), .remain(remain)
  );

endmodule

`default_nettype wire

//--- tests/axiTasks.svh
`ifndef AXI_TASKS_SVH
`define AXI_TASKS_SVH

// Next drive point, just after the rising edge
task automatic nextCycle();
  @(posedge CLK);
  #DriveDelay;
endtask

function automatic int stallLength();
  return $unsigned($random(seed)) % 4;  // 0 to 3 cycles
endfunction

// One write, AW and W offered together
task automatic writeWord(input logic [12:0] addr, input logic [31:0] data);
  logic taken;
  awAddr  = addr;
  awValid = 1'b1;
  wData   = data;
  wValid  = 1'b1;
  do begin
    @(negedge CLK);
    taken = awReady;  // Accepted at the coming edge
    nextCycle();
  end while (!taken);
  awValid = 1'b0;
  wValid  = 1'b0;
  repeat (stallLength()) nextCycle();
  bReady = 1'b1;
  do begin
    @(negedge CLK);
    taken = bValid;
    nextCycle();
  end while (!taken);
  bReady = 1'b0;
endtask

// One read; the R data check runs while checkRData is set
task automatic readCheck(input logic [12:0] addr, input logic [31:0] expected);
  logic taken;
  expRData   = expected;
  checkRData = 1'b1;
  arAddr     = addr;
  arValid    = 1'b1;
  do begin
    @(negedge CLK);
    taken = arReady;
    nextCycle();
  end while (!taken);
  arValid = 1'b0;
  repeat (stallLength()) nextCycle();
  rReady = 1'b1;
  do begin
    @(negedge CLK);
    taken = rValid;
    nextCycle();
  end while (!taken);
  rReady     = 1'b0;
  checkRData = 1'b0;
endtask

`endif

//--- tests/tbPortal.sv
`default_nettype none

module tbPortal;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod  = 40;
  localparam int DriveDelay = 2;
  localparam int NumTests   = 5;
  localparam logic [31:0] Unused = 32'h005A05A0;

  logic CLK;
  logic RST_N;
  logic [12:0] awAddr;
  logic awValid, awReady;
  logic [31:0] wData;
  logic wValid, wReady;
  logic bValid, bReady;
  logic [1:0] bResp;
  logic [12:0] arAddr;
  logic arValid, arReady;
  logic rValid, rReady;
  logic [31:0] rData;
  logic [1:0] rResp;
  logic [127:0] reqMsg;
  logic reqMsgValid, reqMsgReady;
  logic [127:0] indMsg;
  logic indMsgValid, indMsgReady;
  logic interrupt;

  int seed = 96651;
  logic [31:0] expRData;
  logic checkRData;
  logic [31:0] indWords [4];

  // Reference state kept from bus traffic
  logic [127:0] reqShadow = '0;
  logic [127:0] expReqMsg = '0;
  logic [15:0] wordsLeft;
  logic intEnModel;

  logic reqDataAddr;
  logic completeAddr;
  logic popOffer;

  assign reqDataAddr  = awAddr[12] && (awAddr[11:5] != 7'd0);
  assign completeAddr = reqDataAddr && (awAddr[4:0] != 5'd0);
  assign popOffer     = arValid && !arAddr[12] && (arAddr[11:5] != 7'd0) && (arAddr[4:0] == 5'd0);

  portalTop portalTop_inst (.*);

  initial begin
    CLK = 1'b0;
    forever #(ClkPeriod / 2) CLK = ~CLK;
  end

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [127:0] expVal,
                                input logic [127:0] actVal);
    stopWithFailure($sformatf("MISMATCH at %0d ns: %s expected %0h, actual %0h",
                              $time, name, expVal, actVal));
  endtask

  `include "axiTasks.svh"

  always @(posedge CLK) begin
    if (!RST_N) begin
      wordsLeft  <= 16'd0;
      intEnModel <= 1'b0;
    end else begin
      if (indMsgValid && wordsLeft == 16'd0) begin
        wordsLeft <= indMsg[15:0];  // Header low half
      end else if (popOffer && arReady && wordsLeft != 16'd0) begin
        wordsLeft <= wordsLeft - 16'd1;
      end
      if (awValid && awReady && awAddr[11:5] == 7'd0 && awAddr[4:0] == 5'h04) begin
        intEnModel <= wData[0];
      end
      if (awValid && awReady && reqDataAddr) begin
        reqShadow <= {reqShadow[95:0], wData};
        if (completeAddr) begin
          expReqMsg <= {reqShadow[95:0], wData};
        end
      end
    end
  end

  assert property (@(posedge CLK) $rose(RST_N) |-> !bValid && !rValid && !reqMsgValid
                   && !interrupt && !awReady && !wReady && arReady && indMsgReady)
    else stopWithFailure("Outputs were not at their reset values after reset");
  assert property (@(posedge CLK) disable iff (!RST_N)
                   awValid && awReady |-> wValid && wReady)
    else stopWithFailure("AW was accepted without W on the same edge");
  assert property (@(posedge CLK) disable iff (!RST_N) awValid && awReady |=> $rose(bValid))
    else stopWithFailure("BVALID did not rise one cycle after write acceptance");
  assert property (@(posedge CLK) disable iff (!RST_N) $rose(bValid) |-> $past(awValid && awReady))
    else stopWithFailure("BVALID rose without an accepted write");
  assert property (@(posedge CLK) disable iff (!RST_N) arValid && arReady |=> $rose(rValid))
    else stopWithFailure("RVALID did not rise one cycle after read acceptance");
  assert property (@(posedge CLK) disable iff (!RST_N) $rose(rValid) |-> $past(arValid && arReady))
    else stopWithFailure("RVALID rose without an accepted read");
  assert property (@(posedge CLK) disable iff (!RST_N) bValid && !bReady |=> bValid)
    else stopWithFailure("BVALID dropped before BREADY");
  assert property (@(posedge CLK) disable iff (!RST_N)
                   rValid && !rReady |=> rValid && $stable(rData))
    else stopWithFailure("R response changed before RREADY");
  assert property (@(posedge CLK) disable iff (!RST_N) bValid |-> bResp == 2'b00)
    else reportMismatch("bResp", 128'd0, 128'($sampled(bResp)));
  assert property (@(posedge CLK) disable iff (!RST_N) rValid |-> rResp == 2'b00)
    else reportMismatch("rResp", 128'd0, 128'($sampled(rResp)));
  assert property (@(posedge CLK) disable iff (!RST_N)
                   rValid && rReady && checkRData |-> rData == expRData)
    else reportMismatch("rData", 128'($sampled(expRData)), 128'($sampled(rData)));

  // Request channel
  assert property (@(posedge CLK) disable iff (!RST_N)
                   awValid && awReady && completeAddr |=> reqMsgValid)
    else stopWithFailure("reqMsgValid did not follow a completing write");
  assert property (@(posedge CLK) disable iff (!RST_N)
                   reqMsgValid && awValid && completeAddr |-> !awReady)
    else stopWithFailure("Completing write accepted while a message was pending");
  assert property (@(posedge CLK) disable iff (!RST_N)
                   reqMsgValid && !reqMsgReady |=> reqMsgValid && $stable(reqMsg))
    else stopWithFailure("Request message changed before it was taken");
  assert property (@(posedge CLK) disable iff (!RST_N)
                   reqMsgValid && reqMsgReady |-> reqMsg == expReqMsg)
    else reportMismatch("reqMsg", $sampled(expReqMsg), $sampled(reqMsg));

  // Indication channel and interrupt
  assert property (@(posedge CLK) disable iff (!RST_N) indMsgReady == (wordsLeft == 16'd0))
    else reportMismatch("indMsgReady", 128'($sampled(wordsLeft == 16'd0)),
                        128'($sampled(indMsgReady)));
  assert property (@(posedge CLK) disable iff (!RST_N)
                   interrupt == (intEnModel && wordsLeft != 16'd0))
    else reportMismatch("interrupt", 128'($sampled(intEnModel && wordsLeft != 16'd0)),
                        128'($sampled(interrupt)));

  task automatic sendIndication(input int count);
    logic taken;
    for (int i = 0; i < 4; i++) begin
      indWords[i] = $random(seed);
    end
    indWords[0][15:0] = count[15:0];
    indMsg      = {indWords[3], indWords[2], indWords[1], indWords[0]};
    indMsgValid = 1'b1;
    do begin
      @(negedge CLK);
      taken = indMsgReady;
      nextCycle();
    end while (!taken);
    indMsgValid = 1'b0;
  endtask

  task automatic drainIndication(input int count);
    for (int i = 0; i < count; i++) begin
      readCheck(13'h0020, indWords[i]);  // Word i on the i-th pop
    end
  endtask

  task automatic waitReqIdle();
    while (reqMsgValid) nextCycle();
  endtask

  initial begin
    int appended;
    int count;
    RST_N = 1'b0;
    {awAddr, awValid, wData, wValid, bReady} = '0;
    {arAddr, arValid, rReady} = '0;
    {reqMsgReady, indMsg, indMsgValid} = '0;
    expRData   = '0;
    checkRData = 1'b0;
    repeat (3) @(posedge CLK);
    #DriveDelay;
    RST_N = 1'b1;
    nextCycle();

    // Control pages
    readCheck(13'h0008, 32'd1);
    readCheck(13'h0010, 32'd5);
    readCheck(13'h0014, 32'd2);
    readCheck(13'h0000, 32'd0);
    readCheck(13'h0004, Unused);
    readCheck(13'h001C, Unused);
    readCheck(13'h1010, 32'd6);
    readCheck(13'h1008, 32'd1);
    readCheck(13'h1014, 32'd2);
    readCheck(13'h100C, 32'd0);
    readCheck(13'h1018, Unused);
    readCheck(13'h0028, 32'd0);

    // Request message held by the core
    readCheck(13'h1024, 32'd1);
    for (int i = 0; i < 3; i++) begin
      writeWord(13'h1020, $random(seed));
    end
    writeWord(13'h1024, $random(seed));
    readCheck(13'h1024, 32'd0);
    fork
      writeWord(13'h1028, $random(seed));  // Stalls until the first is taken
      begin
        repeat (6) nextCycle();
        readCheck(13'h1024, 32'd0);
        reqMsgReady = 1'b1;
      end
    join
    waitReqIdle();
    reqMsgReady = 1'b0;
    readCheck(13'h1024, 32'd1);
    appended = stallLength();
    repeat (appended) writeWord(13'h1020, $random(seed));
    writeWord(13'h1030, $random(seed));
    reqMsgReady = 1'b1;
    waitReqIdle();

    // Indications with interrupts on, then off
    writeWord(13'h0004, 32'd1);
    count = 1 + stallLength();
    sendIndication(count);
    readCheck(13'h0000, 32'd1);
    readCheck(13'h000C, 32'd1);
    readCheck(13'h1000, 32'd0);
    drainIndication(count);
    readCheck(13'h0000, 32'd0);
    writeWord(13'h1004, 32'd0);
    sendIndication(4);
    readCheck(13'h0000, 32'd1);
    drainIndication(4);
    readCheck(13'h000C, 32'd0);

    repeat (2) nextCycle();
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #(NumTests * 200 * ClkPeriod);
    stopWithFailure("Timeout: the test sequence did not finish in time");
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tests
source/portalPkg.sv
source/axiLiteSlave.sv
source/portalRegs.sv
source/requestAssembler.sv
source/indicationReader.sv
source/portalTop.sv
tests/tbPortal.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbPortal
FILELIST = tb.f
BUILDDIR = obj_dir
LOG      = sim.log
PASSTEXT = Result: PASSED

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
